// File: list.f
+incdir+.
proc_pkg.sv
stage_if.sv
fetch_stage.sv
decode_stage.sv
alu.sv
execute_stage.sv
memory_writeback_stage.sv
processor.sv
processor_properties.sv
processor_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile the processor testbench with verilator and run it
# exit status is nonzero when the log holds the fail line
cd "$(dirname "$0")" || exit 1
set -o pipefail

verilator --binary --timing --assert -f list.f --top-module processor_tb -o processor_sim \
    && ./obj_dir/processor_sim 2>&1 | tee sim.log \
    || { echo "build or simulation did not complete"; exit 1; }

grep -q "Finished with errors" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "no summary line in sim.log"; exit 1; }
echo "simulation passed"

// File: processor_tb.sv
//**************************************************************************
// testbench: imem, dmem and register-file models, directed program tests,
// watchdog and error summary
//**************************************************************************
`include "proc_defines.svh"

module processor_tb;
    import proc_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_TESTS  = 5;
    localparam int RUN_CYCLES = 60;                     // every program parks by then
    localparam int TIMEOUT    = NUM_TESTS * 80 * CLK_PERIOD;

    logic     clock;
    logic     rst_n;
    word_t    address_imem;
    word_t    q_imem = '0;
    word_t    address_dmem;
    word_t    data;
    logic     wren;
    word_t    q_dmem = '0;
    logic     ctrl_write_enable;
    reg_idx_t ctrl_write_reg;
    reg_idx_t ctrl_read_reg_a;
    reg_idx_t ctrl_read_reg_b;
    word_t    data_write_reg;
    word_t    data_read_reg_a;
    word_t    data_read_reg_b;

    word_t       imem [256];
    word_t       dmem [256];
    word_t       regs [32];
    int          prog_len;      // next free imem slot
    int          errors;
    int          checks;

    processor UUT (
        .clock             (clock),
        .rst_n             (rst_n),
        .address_imem      (address_imem),
        .q_imem            (q_imem),
        .address_dmem      (address_dmem),
        .data              (data),
        .wren              (wren),
        .q_dmem            (q_dmem),
        .ctrl_write_enable (ctrl_write_enable),
        .ctrl_write_reg    (ctrl_write_reg),
        .ctrl_read_reg_a   (ctrl_read_reg_a),
        .ctrl_read_reg_b   (ctrl_read_reg_b),
        .data_write_reg    (data_write_reg),
        .data_read_reg_a   (data_read_reg_a),
        .data_read_reg_b   (data_read_reg_b)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // both memories answer one edge after the address
    always @(posedge clock) begin
        q_imem <= imem[address_imem[7:0]];
        q_dmem <= dmem[address_dmem[7:0]];      // old word on a write cycle
        if (wren) begin
            dmem[address_dmem[7:0]] <= data;
        end
        if (ctrl_write_enable && (ctrl_write_reg != '0)) begin
            regs[ctrl_write_reg] <= data_write_reg;
        end
    end

    // register reads see a same-cycle write, r0 stays zero
    always_comb begin
        data_read_reg_a = regs[ctrl_read_reg_a];
        data_read_reg_b = regs[ctrl_read_reg_b];
        if (ctrl_write_enable && (ctrl_write_reg == ctrl_read_reg_a)) begin
            data_read_reg_a = data_write_reg;
        end
        if (ctrl_write_enable && (ctrl_write_reg == ctrl_read_reg_b)) begin
            data_read_reg_b = data_write_reg;
        end
        if (ctrl_read_reg_a == '0) data_read_reg_a = '0;
        if (ctrl_read_reg_b == '0) data_read_reg_b = '0;
    end

    // encoders follow the field layout, r-type low two bits unused
    function automatic word_t rtype_word(input alu_op_t fn, input int rd, input int rs,
                                         input int rt, input int sh);
        return {`OP_RTYPE, 5'(rd), 5'(rs), 5'(rt), 5'(sh), fn, 2'b00};
    endfunction

    function automatic word_t itype_word(input opcode_t op, input int rd, input int rs,
                                         input int imm);
        return {op, 5'(rd), 5'(rs), 17'(imm)};
    endfunction

    function automatic word_t jtype_word(input opcode_t op, input int tgt);
        return {op, 27'(tgt)};
    endfunction

    function automatic word_t sign_extend(input int v);
        logic [16:0] s;
        s = 17'(v);
        return {{15{s[16]}}, s};
    endfunction

    task automatic emit(input word_t w);
        imem[8'(prog_len)] = w;
        prog_len++;
    endtask

    task automatic check_value(input string test_name, input string what,
                               input word_t expected, input word_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s %s: expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    // hold reset while the old program drains, then wipe the models
    task automatic begin_test();
        @(negedge clock);
        rst_n = 1'b0;
        repeat (2) @(negedge clock);
        foreach (imem[i]) imem[i] = '0;         // nop everywhere
        foreach (dmem[i]) dmem[i] = '0;
        foreach (regs[i]) regs[i] = '0;
        prog_len = 0;
    endtask

    // self-jump closes the program, reset totals 5 cycles
    task automatic run_program();
        emit(jtype_word(`OP_J, prog_len));
        repeat (3) @(negedge clock);
        rst_n = 1'b1;
        repeat (RUN_CYCLES) @(negedge clock);
    endtask

    task automatic alu_chain_test();
        int    k1, k2, sh1, sh2;
        int    r;
        word_t e [32];
        begin_test();
        k1  = $urandom_range(0, 131071);
        k2  = $urandom_range(0, 131071);
        sh1 = $urandom_range(0, 31);
        sh2 = $urandom_range(0, 31);
        emit(itype_word(`OP_ADDI, 1, 0, k1));
        emit(itype_word(`OP_ADDI, 2, 1, k2));       // r1 from memory stage
        emit(rtype_word(`ALU_ADD, 3, 1, 2, 0));     // r1 writeback, r2 memory
        emit(rtype_word(`ALU_SUB, 4, 3, 1, 0));
        emit(rtype_word(`ALU_AND, 5, 4, 3, 0));
        emit(rtype_word(`ALU_OR, 6, 5, 2, 0));
        emit(rtype_word(`ALU_SLL, 7, 6, 0, sh1));
        emit(rtype_word(`ALU_SRA, 8, 7, 0, sh2));
        run_program();
        e[1] = sign_extend(k1);
        e[2] = e[1] + sign_extend(k2);
        e[3] = e[1] + e[2];
        e[4] = e[3] - e[1];
        e[5] = e[4] & e[3];
        e[6] = e[5] | e[2];
        e[7] = e[6] << sh1;
        e[8] = $signed(e[7]) >>> sh2;               // arithmetic, sign fill
        for (r = 1; r <= 8; r++) begin
            check_value("alu_chain", $sformatf("r%0d", r), e[5'(r)], regs[5'(r)]);
        end
    endtask

    task automatic load_use_test();
        int    base, k;
        word_t v;
        begin_test();
        base = $urandom_range(8, 200);
        k    = $urandom_range(0, 131071);
        emit(itype_word(`OP_ADDI, 1, 0, base));
        emit(itype_word(`OP_ADDI, 2, 0, k));
        emit(itype_word(`OP_SW, 2, 1, 3));          // mem[r1+3] = r2
        emit(itype_word(`OP_LW, 3, 1, 3));
        emit(rtype_word(`ALU_ADD, 4, 3, 1, 0));     // needs the one-cycle bubble
        emit(rtype_word(`ALU_ADD, 5, 4, 3, 0));
        run_program();
        v = sign_extend(k);
        check_value("load_use", "mem", v, dmem[8'(base + 3)]);
        check_value("load_use", "r3", v, regs[3]);
        check_value("load_use", "r4", v + word_t'(base), regs[4]);
        check_value("load_use", "r5", v + word_t'(base) + v, regs[5]);
    endtask

    task automatic store_bypass_test();
        int    addr;
        word_t v;
        begin_test();
        addr = $urandom_range(8, 200);
        v    = $urandom;
        dmem[8'(addr)] = v;
        emit(itype_word(`OP_ADDI, 1, 0, addr));
        emit(itype_word(`OP_LW, 2, 1, 0));
        emit(itype_word(`OP_SW, 2, 1, 5));          // data only ready in writeback
        emit(itype_word(`OP_LW, 3, 1, 5));
        emit(rtype_word(`ALU_ADD, 4, 3, 2, 0));
        run_program();
        check_value("store_bypass", "mem", v, dmem[8'(addr + 5)]);
        check_value("store_bypass", "r2", v, regs[2]);
        check_value("store_bypass", "r3", v, regs[3]);
        check_value("store_bypass", "r4", v + v, regs[4]);
    endtask

    task automatic branch_test();
        int    k;
        word_t v;
        begin_test();
        k = $urandom_range(0, 131071);
        emit(itype_word(`OP_ADDI, 1, 0, k));
        emit(itype_word(`OP_ADDI, 2, 1, 5));        // r2 = r1 + 5
        emit(itype_word(`OP_BNE, 1, 2, 2));         // taken, to 5
        emit(itype_word(`OP_ADDI, 10, 0, 1));
        emit(itype_word(`OP_ADDI, 11, 0, 1));
        emit(itype_word(`OP_BLT, 2, 1, 2));         // r2 < r1 false
        emit(itype_word(`OP_ADDI, 12, 0, 7));
        emit(itype_word(`OP_BLT, 1, 2, 2));         // taken, to 10
        emit(itype_word(`OP_ADDI, 13, 0, 1));
        emit(itype_word(`OP_ADDI, 14, 0, 1));
        emit(itype_word(`OP_BNE, 1, 1, 2));         // equal, falls through
        emit(itype_word(`OP_ADDI, 15, 0, 9));
        run_program();
        v = sign_extend(k);
        check_value("branch", "r1", v, regs[1]);
        check_value("branch", "r2", v + 32'd5, regs[2]);
        check_value("branch", "r10", '0, regs[10]);
        check_value("branch", "r11", '0, regs[11]);
        check_value("branch", "r12", 32'd7, regs[12]);
        check_value("branch", "r13", '0, regs[13]);
        check_value("branch", "r14", '0, regs[14]);
        check_value("branch", "r15", 32'd9, regs[15]);
    endtask

    task automatic jump_test();
        int k;
        begin_test();
        k = $urandom_range(0, 65535);
        emit(itype_word(`OP_ADDI, 1, 0, k));
        emit(jtype_word(`OP_JAL, 5));               // link = 2
        emit(itype_word(`OP_ADDI, 3, 1, 1));        // return lands here
        emit(jtype_word(`OP_J, 9));
        emit(itype_word(`OP_ADDI, 4, 0, 1));        // never reached
        emit(itype_word(`OP_ADDI, 2, 0, 3));        // subroutine
        emit(itype_word(`OP_JR, 31, 0, 0));
        emit(itype_word(`OP_ADDI, 5, 0, 1));
        emit(itype_word(`OP_ADDI, 6, 0, 1));
        emit(itype_word(`OP_ADDI, 8, 0, 11));
        run_program();
        check_value("jump", "r31", 32'd2, regs[31]);
        check_value("jump", "r2", 32'd3, regs[2]);
        check_value("jump", "r3", sign_extend(k) + 32'd1, regs[3]);
        check_value("jump", "r4", '0, regs[4]);
        check_value("jump", "r5", '0, regs[5]);
        check_value("jump", "r6", '0, regs[6]);
        check_value("jump", "r8", 32'd11, regs[8]);
    endtask

    initial begin
        #(TIMEOUT);
        $display("timeout: the tests did not finish within %0d time units", TIMEOUT);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        rst_n  = 1'b0;
        errors = 0;
        checks = 0;
        void'($urandom(32'h42cb));
        alu_chain_test();
        load_use_test();
        store_bypass_test();
        branch_test();
        jump_test();
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: processor_properties.sv
//**************************************************************************
// concurrent checks on the processor top-level ports, bound into processor
//**************************************************************************
module processor_properties (
    input logic               clock,
    input logic               rst_n,
    input proc_pkg::word_t    address_imem,
    input logic               wren,
    input logic               ctrl_write_enable,
    input proc_pkg::reg_idx_t ctrl_write_reg
);

    // r0 is never a write target
    write_reg_nonzero: assert property (
        @(posedge clock) disable iff (!rst_n) ctrl_write_enable |-> (ctrl_write_reg != '0)
    ) else $error("register write enabled with index zero");

    // latches hold nops right out of reset
    quiet_after_reset: assert property (
        @(posedge clock) $rose(rst_n) |-> (!wren && !ctrl_write_enable)
    ) else $error("memory or register write in the first cycle after reset");

    imem_address_known: assert property (
        @(posedge clock) disable iff (!rst_n) !$isunknown(address_imem)
    ) else $error("instruction address has unknown bits");

endmodule

bind processor processor_properties u_properties (
    .clock             (clock),
    .rst_n             (rst_n),
    .address_imem      (address_imem),
    .wren              (wren),
    .ctrl_write_enable (ctrl_write_enable),
    .ctrl_write_reg    (ctrl_write_reg)
);

// File: processor.sv
//**************************************************************************
// processor: five-stage pipeline top, external memory and regfile ports
//**************************************************************************
module processor (
    input  logic               clock,
    input  logic               rst_n,
    // imem
    output proc_pkg::word_t    address_imem,
    input  proc_pkg::word_t    q_imem,
    // dmem
    output proc_pkg::word_t    address_dmem,
    output proc_pkg::word_t    data,
    output logic               wren,
    input  proc_pkg::word_t    q_dmem,
    // regfile
    output logic               ctrl_write_enable,
    output proc_pkg::reg_idx_t ctrl_write_reg,
    output proc_pkg::reg_idx_t ctrl_read_reg_a,
    output proc_pkg::reg_idx_t ctrl_read_reg_b,
    output proc_pkg::word_t    data_write_reg,
    input  proc_pkg::word_t    data_read_reg_a,
    input  proc_pkg::word_t    data_read_reg_b
);
    import proc_pkg::*;

    logic     stall;        // decode -> fetch
    logic     redirect;     // execute -> fetch, decode
    word_t    target;
    logic     wb_en;        // writeback bypass into execute
    reg_idx_t wb_rd;
    word_t    wb_data;

    stage_if fd ();
    stage_if dx ();
    stage_if xm ();

    fetch_stage u_fetch (
        .clock        (clock),
        .rst_n        (rst_n),
        .stall        (stall),
        .redirect     (redirect),
        .target       (target),
        .address_imem (address_imem),
        .q_imem       (q_imem),
        .fd           (fd.writer)
    );

    decode_stage u_decode (
        .clock           (clock),
        .rst_n           (rst_n),
        .redirect        (redirect),
        .fd              (fd.reader),
        .ctrl_read_reg_a (ctrl_read_reg_a),
        .ctrl_read_reg_b (ctrl_read_reg_b),
        .data_read_reg_a (data_read_reg_a),
        .data_read_reg_b (data_read_reg_b),
        .stall           (stall),
        .dx              (dx.writer)
    );

    execute_stage u_execute (
        .clock    (clock),
        .rst_n    (rst_n),
        .dx       (dx.reader),
        .wb_en    (wb_en),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .redirect (redirect),
        .target   (target),
        .xm       (xm.writer)
    );

    memory_writeback_stage u_memory_writeback (
        .clock             (clock),
        .rst_n             (rst_n),
        .xm                (xm.reader),
        .address_dmem      (address_dmem),
        .data              (data),
        .wren              (wren),
        .q_dmem            (q_dmem),
        .ctrl_write_enable (ctrl_write_enable),
        .ctrl_write_reg    (ctrl_write_reg),
        .data_write_reg    (data_write_reg),
        .wb_en             (wb_en),
        .wb_rd             (wb_rd),
        .wb_data           (wb_data)
    );

endmodule

// File: memory_writeback_stage.sv
//**************************************************************************
// memory and writeback: dmem drive, store-data bypass, m/w latch, reg write
//**************************************************************************
`include "proc_defines.svh"

module memory_writeback_stage (
    input  logic               clock,
    input  logic               rst_n,
    stage_if.reader            xm,
    output proc_pkg::word_t    address_dmem,
    output proc_pkg::word_t    data,
    output logic               wren,
    input  proc_pkg::word_t    q_dmem,
    output logic               ctrl_write_enable,
    output proc_pkg::reg_idx_t ctrl_write_reg,
    output proc_pkg::word_t    data_write_reg,
    output logic               wb_en,
    output proc_pkg::reg_idx_t wb_rd,
    output proc_pkg::word_t    wb_data
);
    import proc_pkg::*;

    opcode_t  m_op;
    reg_idx_t m_rd;
    word_t    mw_ir;        // m/w latch
    word_t    mw_o;
    opcode_t  w_op;
    reg_idx_t w_rd;
    logic     w_writes;
    word_t    w_data;

    assign m_op = xm.ir[`F_OPCODE];
    assign m_rd = xm.ir[`F_RD];

    // dmem, read data comes back on q_dmem one edge later
    assign address_dmem = xm.o;
    assign wren         = (m_op == `OP_SW);
    // lw directly ahead of sw lands here
    assign data         = (w_writes && (w_rd == m_rd)) ? w_data : xm.b;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            mw_ir <= '0;
        end else begin
            mw_ir <= xm.ir;
        end
    end

    always_ff @(posedge clock) begin
        mw_o <= xm.o;
    end

    assign w_op = mw_ir[`F_OPCODE];
    assign w_rd = mw_ir[`F_RD];

    // r0 never written, so the nop is harmless
    assign w_writes = ((w_op == `OP_RTYPE) || (w_op == `OP_ADDI) ||
                       (w_op == `OP_LW) || (w_op == `OP_JAL)) && (w_rd != '0);
    assign w_data   = (w_op == `OP_LW) ? q_dmem : mw_o;

    // register file write port
    assign ctrl_write_enable = w_writes;
    assign ctrl_write_reg    = w_rd;
    assign data_write_reg    = w_data;

    // bypass source for execute
    assign wb_en   = w_writes;
    assign wb_rd   = w_rd;
    assign wb_data = w_data;

endmodule

// File: execute_stage.sv
//**************************************************************************
// execute stage: operand bypass, alu, branch/jump resolve, x/m latch
//**************************************************************************
`include "proc_defines.svh"

module execute_stage (
    input  logic               clock,
    input  logic               rst_n,
    stage_if.reader            dx,
    input  logic               wb_en,
    input  proc_pkg::reg_idx_t wb_rd,
    input  proc_pkg::word_t    wb_data,
    output logic               redirect,
    output proc_pkg::word_t    target,
    stage_if.writer            xm
);
    import proc_pkg::*;

    opcode_t  x_op;
    reg_idx_t x_rd;
    reg_idx_t x_rs;
    reg_idx_t x_rt;
    reg_idx_t src_b;        // register behind dx.b
    word_t    x_imm;
    word_t    x_jump_target;
    opcode_t  m_op;
    reg_idx_t m_rd;
    logic     m_writes;     // xm instruction holds a register result in o
    logic     is_branch;
    logic     use_imm;
    logic     taken;
    word_t    a_val;
    word_t    b_val;
    word_t    alu_a;
    word_t    alu_b;
    alu_op_t  alu_op;
    word_t    alu_result;
    logic     not_equal;
    logic     less_than;
    word_t    xm_ir_next;

    // memory stage first, then writeback, else the register file value
    function automatic word_t bypass(input reg_idx_t idx, input word_t latched);
        word_t val;
        val = latched;
        if (idx != '0) begin
            if (m_writes && (m_rd == idx)) begin
                val = xm.o;
            end else if (wb_en && (wb_rd == idx)) begin
                val = wb_data;
            end
        end
        return val;
    endfunction

    assign x_op          = dx.ir[`F_OPCODE];
    assign x_rd          = dx.ir[`F_RD];
    assign x_rs          = dx.ir[`F_RS];
    assign x_rt          = dx.ir[`F_RT];
    assign x_imm         = {{(`WORD_W - `IMM_W){dx.ir[`IMM_W-1]}}, dx.ir[`F_IMM]};
    assign x_jump_target = word_t'(dx.ir[`F_TARGET]);
    assign m_op          = xm.ir[`F_OPCODE];
    assign m_rd          = xm.ir[`F_RD];

    // lw is left out, its o is only the address
    assign m_writes = ((m_op == `OP_RTYPE) || (m_op == `OP_ADDI) || (m_op == `OP_JAL)) &&
                      (m_rd != '0);

    assign is_branch = (x_op == `OP_BNE) || (x_op == `OP_BLT);
    assign use_imm   = (x_op == `OP_ADDI) || (x_op == `OP_LW) || (x_op == `OP_SW);
    assign src_b     = (is_branch || (x_op == `OP_SW) || (x_op == `OP_JR)) ? x_rd : x_rt;

    always_comb begin
        a_val = bypass(x_rs, dx.a);
        b_val = bypass(src_b, dx.b);
    end

    // branches compare $rd against $rs, so the operands swap
    assign alu_a  = is_branch ? b_val : a_val;
    assign alu_b  = use_imm ? x_imm : (is_branch ? a_val : b_val);
    assign alu_op = (x_op == `OP_RTYPE) ? dx.ir[`F_ALU_OP] : `ALU_ADD;

    alu u_alu (
        .operand_a (alu_a),
        .operand_b (alu_b),
        .alu_op    (alu_op),
        .shamt     (dx.ir[`F_SHAMT]),
        .result    (alu_result),
        .not_equal (not_equal),
        .less_than (less_than)
    );

    assign taken = ((x_op == `OP_BNE) && not_equal) || ((x_op == `OP_BLT) && less_than);

    always_comb begin
        redirect = 1'b0;
        target   = dx.pc + x_imm;       // dx.pc is already pc+1
        if (taken) begin
            redirect = 1'b1;
        end else if ((x_op == `OP_J) || (x_op == `OP_JAL)) begin
            redirect = 1'b1;
            target   = x_jump_target;
        end else if (x_op == `OP_JR) begin
            redirect = 1'b1;
            target   = b_val;           // $rd through port b
        end
    end

    // jal retargets its write to the link register
    always_comb begin
        xm_ir_next = dx.ir;
        if (x_op == `OP_JAL) begin
            xm_ir_next[`F_RD] = `LINK_REG;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            xm.ir <= '0;
        end else begin
            xm.ir <= xm_ir_next;
        end
    end

    always_ff @(posedge clock) begin
        xm.o <= (x_op == `OP_JAL) ? dx.pc : alu_result;   // link value is pc+1
        xm.b <= b_val;                                     // store data
    end

    assign xm.pc = '0;
    assign xm.a  = '0;

endmodule

// File: alu.sv
//**************************************************************************
// alu: add, sub, and, or, sll, sra plus signed compare flags
//**************************************************************************
`include "proc_defines.svh"

module alu (
    input  proc_pkg::word_t   operand_a,
    input  proc_pkg::word_t   operand_b,
    input  proc_pkg::alu_op_t alu_op,
    input  proc_pkg::shamt_t  shamt,
    output proc_pkg::word_t   result,
    output logic              not_equal,
    output logic              less_than
);
    import proc_pkg::*;

    always_comb begin
        case (alu_op)
            `ALU_ADD: begin
                result = operand_a + operand_b;     // also address calc
            end
            `ALU_SUB: begin
                result = operand_a - operand_b;
            end
            `ALU_AND: begin
                result = operand_a & operand_b;
            end
            `ALU_OR: begin
                result = operand_a | operand_b;
            end
            `ALU_SLL: begin
                result = operand_a << shamt;        // shift a, b unused
            end
            `ALU_SRA: begin
                result = word_t'($signed(operand_a) >>> shamt);  // sign fill
            end
            default: begin
                result = '0;                        // undefined ops give zero
            end
        endcase
    end

    // branch flags, independent of alu_op
    assign not_equal = operand_a != operand_b;
    assign less_than = $signed(operand_a) < $signed(operand_b);

endmodule

// File: decode_stage.sv
//**************************************************************************
// decode stage: field split, register read, load-use check, d/x latch
//**************************************************************************
`include "proc_defines.svh"

module decode_stage (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               redirect,
    stage_if.reader            fd,
    output proc_pkg::reg_idx_t ctrl_read_reg_a,
    output proc_pkg::reg_idx_t ctrl_read_reg_b,
    input  proc_pkg::word_t    data_read_reg_a,
    input  proc_pkg::word_t    data_read_reg_b,
    output logic               stall,
    stage_if.writer            dx
);
    import proc_pkg::*;

    opcode_t  d_op;
    reg_idx_t d_rd;
    reg_idx_t d_rs;
    reg_idx_t d_rt;
    opcode_t  x_op;         // instruction one stage ahead
    reg_idx_t x_rd;
    logic     b_from_rd;    // port b names rd instead of rt
    logic     uses_rs;
    logic     uses_b;

    assign d_op = fd.ir[`F_OPCODE];
    assign d_rd = fd.ir[`F_RD];
    assign d_rs = fd.ir[`F_RS];
    assign d_rt = fd.ir[`F_RT];
    assign x_op = dx.ir[`F_OPCODE];
    assign x_rd = dx.ir[`F_RD];

    // sw data, branch compare and jr target all sit in rd
    assign b_from_rd = (d_op == `OP_SW) || (d_op == `OP_BNE) ||
                       (d_op == `OP_BLT) || (d_op == `OP_JR);

    assign ctrl_read_reg_a = d_rs;
    assign ctrl_read_reg_b = b_from_rd ? d_rd : d_rt;

    // j, jal and jr carry no rs, only r-type uses rt
    assign uses_rs = !((d_op == `OP_J) || (d_op == `OP_JAL) || (d_op == `OP_JR));
    assign uses_b  = b_from_rd || (d_op == `OP_RTYPE);

    // lw result is not ready for execute next cycle
    // sw data is exempt, memory stage picks it up from writeback
    assign stall = (x_op == `OP_LW) && (x_rd != '0) &&
                   ((uses_rs && (d_rs == x_rd)) ||
                    (uses_b && (d_op != `OP_SW) && (ctrl_read_reg_b == x_rd)));

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            dx.ir <= '0;
        end else if (stall || redirect) begin
            dx.ir <= '0;            // bubble
        end else begin
            dx.ir <= fd.ir;
        end
    end

    always_ff @(posedge clock) begin
        dx.pc <= fd.pc;
        dx.a  <= data_read_reg_a;
        dx.b  <= data_read_reg_b;
    end

    assign dx.o = '0;   // result is produced in execute

endmodule

// File: fetch_stage.sv
//**************************************************************************
// fetch stage: program counter, next-pc select, fetch/decode latch
//**************************************************************************
module fetch_stage (
    input  logic            clock,
    input  logic            rst_n,
    input  logic            stall,          // load-use hold from decode
    input  logic            redirect,       // taken branch or jump in execute
    input  proc_pkg::word_t target,
    output proc_pkg::word_t address_imem,
    input  proc_pkg::word_t q_imem,
    stage_if.writer         fd
);
    import proc_pkg::*;

    word_t pc;          // address of the word now on q_imem
    word_t pc_plus_1;
    word_t next_pc;
    logic  primed;      // low in the first cycle out of reset

    assign pc_plus_1 = pc + word_t'(1);

    // redirect wins, stall and the warm-up cycle replay the same address
    always_comb begin
        if (redirect) begin
            next_pc = target;
        end else if (stall || !primed) begin
            next_pc = pc;
        end else begin
            next_pc = pc_plus_1;
        end
    end

    assign address_imem = next_pc;      // imem samples it at the edge

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pc     <= '0;
            primed <= 1'b0;
            fd.ir  <= '0;
        end else begin
            pc     <= next_pc;
            primed <= 1'b1;
            if (redirect || !primed) begin
                fd.ir <= '0;            // wrong-path or stale word becomes a nop
            end else if (!stall) begin
                fd.ir <= q_imem;
            end                         // on stall the word recirculates
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            fd.pc <= pc_plus_1;         // pc+1 travels with the word
        end
    end

    // fd has no operands or result
    assign fd.a = '0;
    assign fd.b = '0;
    assign fd.o = '0;

endmodule

// File: stage_if.sv
//**************************************************************************
// stage_if: one pipeline latch between two stages
//**************************************************************************
interface stage_if;
    import proc_pkg::*;

    word_t ir;      // instruction, all zero is the nop
    word_t pc;      // pc+1 of the instruction
    word_t a;       // port a operand
    word_t b;       // port b operand or store data
    word_t o;       // alu result, address or link value

    // stage that loads the latch
    modport writer (
        output ir,
        output pc,
        output a,
        output b,
        output o
    );

    // next stage down
    modport reader (
        input ir,
        input pc,
        input a,
        input b,
        input o
    );

endinterface

// File: proc_pkg.sv
//**************************************************************************
// shared datapath types of the pipelined processor
//**************************************************************************
`include "proc_defines.svh"

package proc_pkg;

    // one data word, also used for instruction and pc values
    typedef logic [`WORD_W-1:0] word_t;

    // register file index, 32 registers, r0 hardwired to zero
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;

    typedef logic [`OPCODE_W-1:0] opcode_t;   // bits 31..27 of the word

    // r-type operation select
    typedef logic [`ALU_OP_W-1:0] alu_op_t;

    typedef logic [`SHAMT_W-1:0] shamt_t;     // sll/sra distance

endpackage

// File: proc_defines.svh
//**************************************************************************
// widths, instruction field positions, opcodes and alu op codes
//**************************************************************************
`ifndef PROC_DEFINES_SVH
`define PROC_DEFINES_SVH

`define WORD_W     32          // data and address width
`define REG_IDX_W  5
`define OPCODE_W   5
`define ALU_OP_W   5
`define SHAMT_W    5
`define IMM_W      17          // i-type immediate, sign-extended
`define LINK_REG   5'd31       // jal return register

// instruction fields
`define F_OPCODE   31:27
`define F_RD       26:22
`define F_RS       21:17
`define F_RT       16:12
`define F_SHAMT    11:7
`define F_ALU_OP   6:2
`define F_IMM      16:0
`define F_TARGET   26:0        // j/jal target, zero-extended

// opcodes
`define OP_RTYPE   5'd0
`define OP_J       5'd1
`define OP_BNE     5'd2
`define OP_JAL     5'd3
`define OP_JR      5'd4
`define OP_ADDI    5'd5
`define OP_BLT     5'd6
`define OP_SW      5'd7
`define OP_LW      5'd8

// r-type alu op field
`define ALU_ADD    5'd0
`define ALU_SUB    5'd1
`define ALU_AND    5'd2
`define ALU_OR     5'd3
`define ALU_SLL    5'd4
`define ALU_SRA    5'd5

`endif
